// ==== hdl/ucstats_pkg.sv ====
// stat bridge types, uc and bank state encodings, address spaces and protocol words
package ucstats_pkg;

   // --------------------
   // payload types
   // --------------------
   localparam int BYTES_PER_WORD = 4;

   typedef logic [7:0] uc_byte_t;
   typedef logic [8*BYTES_PER_WORD-1:0] stat_word_t;
   // [15] write, [14:11] must be zero, [11:10] space, [9:0] offset
   typedef logic [15:0] uc_addr_t;
   // [9:5] sfp select, [4:0] word within the sfp block
   typedef logic [9:0] ram_addr_t;

   // address spaces
   localparam logic [1:0] SPACE_STAT = 2'd0;
   localparam logic [1:0] SPACE_FPGA = 2'd1;

   // fpga space offsets, interval done is write only and id code read only
   localparam logic [9:0] OFS_INTERVAL_DONE = 10'd1;
   localparam logic [9:0] OFS_ID_CODE       = 10'd2;

   localparam stat_word_t ID_CODE       = 32'hC001_C0DE;
   localparam stat_word_t BAD_ADDR_WORD = 32'hDEAD_BEEF;

   // --------------------
   // state encodings
   // --------------------
   typedef enum logic [4:0] {
      UC_IDLE       = 5'h00,
      UC_ADDR0      = 5'h01,
      UC_ADDR1      = 5'h02,
      UC_ADDR_DEC   = 5'h03,
      UC_DATA0      = 5'h04,
      UC_DATA0_B    = 5'h05,
      UC_DATA1      = 5'h06,
      UC_DATA2      = 5'h07,
      UC_DATA3      = 5'h08,
      UC_WR_RAM     = 5'h09,
      UC_RD_RAM     = 5'h0A,
      UC_RD_MASTER  = 5'h0B,
      UC_RD_MASTER2 = 5'h0C,
      UC_RD_DRIVE0  = 5'h0D,
      UC_RD_DRIVE1  = 5'h0E,
      UC_RD_DRIVE2  = 5'h0F,
      UC_RD_DRIVE3  = 5'h10,
      UC_EARLY_DONE = 5'h11,
      UC_RD_DONE    = 5'h12,
      UC_DONE       = 5'h13,
      UC_INVALID_WR = 5'h14,
      UC_ERROR      = 5'h1F
   } uc_state_t;

   typedef enum logic [2:0] {
      BANK_IDLE          = 3'h0,
      BANK_WRITING       = 3'h1,
      BANK_INTERVAL_DONE = 3'h2,
      BANK_UPDATE        = 3'h3,
      BANK_ERROR         = 3'h7
   } bank_state_t;

endpackage

// ==== hdl/uc_input_sync.sv ====
`timescale 1ns/1ps
// two-flop synchronizers, control debounce and valid edge pulses for the uc pins
module uc_input_sync #(
   parameter int DEBOUNCE_LEN = 2
) (
   input  logic                  clk,
   input  logic                  uc_rst_n,
   input  logic                  uc_cs,
   input  logic                  uc_valid,
   input  logic                  uc_master,
   input  ucstats_pkg::uc_byte_t uc_data_in,
   output logic                  cs_db,
   output logic                  master_db,
   output logic                  valid_rise,
   output logic                  valid_fall,
   output ucstats_pkg::uc_byte_t data_sync
);

   localparam int CNT_W = $clog2(DEBOUNCE_LEN + 1);

   // control pins travel packed as {master, valid, cs}
   logic [2:0]            ctl_meta;
   logic [2:0]            ctl_sync;
   logic [2:0]            ctl_db;
   logic [CNT_W-1:0]      run_cnt [3];
   ucstats_pkg::uc_byte_t data_meta;
   logic                  valid_q;

   // --------------------
   // synchronizers
   // --------------------
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         ctl_meta <= '0;
         ctl_sync <= '0;
      end else begin
         ctl_meta <= {uc_master, uc_valid, uc_cs};
         ctl_sync <= ctl_meta;
      end
   end

   // data settles long before the debounced valid edge
   always_ff @(posedge clk) begin
      data_meta <= uc_data_in;
      data_sync <= data_meta;
   end

   // --------------------
   // debounce
   // --------------------
   // level follows only after DEBOUNCE_LEN equal samples that differ from it
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         ctl_db <= '0;
         for (int i = 0; i < 3; i++) begin
            run_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 3; i++) begin
            if (ctl_sync[i] == ctl_db[i]) begin
               // glitch back to the old level restarts the run
               run_cnt[i] <= '0;
            end else if (run_cnt[i] == CNT_W'(DEBOUNCE_LEN - 1)) begin
               ctl_db[i]  <= ctl_sync[i];
               run_cnt[i] <= '0;
            end else begin
               run_cnt[i] <= run_cnt[i] + 1'b1;
            end
         end
      end
   end

   // one cycle delay of debounced valid for edge detect
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= ctl_db[1];
      end
   end

   assign cs_db      = ctl_db[0];
   assign master_db  = ctl_db[2];
   assign valid_rise = ctl_db[1] & ~valid_q;
   assign valid_fall = ~ctl_db[1] & valid_q;

endmodule

// ==== hdl/uc_xfer_fsm.sv ====
`timescale 1ns/1ps
// uc transfer fsm with address and data accumulation, address decode and byte-wise read drive
module uc_xfer_fsm (
   input  logic                    clk,
   input  logic                    uc_rst_n,
   input  logic                    cs_db,
   input  logic                    master_db,
   input  logic                    valid_rise,
   input  logic                    valid_fall,
   input  ucstats_pkg::uc_byte_t   data_sync,
   input  ucstats_pkg::stat_word_t uc_rd_data,
   output logic                    wr_pulse,
   output logic                    rd_pulse,
   output logic                    interval_pulse,
   output ucstats_pkg::ram_addr_t  uc_ram_addr,
   output ucstats_pkg::stat_word_t uc_wr_data,
   output ucstats_pkg::uc_byte_t   uc_data_out,
   output logic                    uc_data_out_val
);

   ucstats_pkg::uc_state_t  state;
   ucstats_pkg::uc_addr_t   uc_addr;
   ucstats_pkg::stat_word_t data_to_uc;
   logic                    rd_issued;
   logic                    is_write;
   logic                    is_stat;
   logic                    is_fpga;
   logic                    is_interval;
   logic                    is_id_read;
   logic                    invalid_addr;

   // --------------------
   // transfer fsm
   // --------------------
   // cs negation mid transfer lands in early done, the fsm then rearms from idle
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         state <= ucstats_pkg::UC_IDLE;
      end else begin
         case (state)
            ucstats_pkg::UC_IDLE:
               state <= cs_db ? ucstats_pkg::UC_ADDR0 : state;
            // address low then high byte
            ucstats_pkg::UC_ADDR0:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        valid_rise ? ucstats_pkg::UC_ADDR1 : state;
            ucstats_pkg::UC_ADDR1:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        valid_rise ? ucstats_pkg::UC_ADDR_DEC : state;
            // invalid read skips the ram and returns the bad address word
            ucstats_pkg::UC_ADDR_DEC:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        is_write ? (invalid_addr ? ucstats_pkg::UC_INVALID_WR :
                                                   ucstats_pkg::UC_DATA0) :
                        (invalid_addr || !is_stat) ? ucstats_pkg::UC_RD_MASTER :
                        ucstats_pkg::UC_RD_RAM;
            ucstats_pkg::UC_DATA0:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        valid_rise ? ucstats_pkg::UC_DATA1 : state;
            // repeat word, cs drop here is a normal end of a burst
            ucstats_pkg::UC_DATA0_B:
               state <= !cs_db ? ucstats_pkg::UC_DONE :
                        valid_rise ? ucstats_pkg::UC_DATA1 : state;
            ucstats_pkg::UC_DATA1:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        valid_rise ? ucstats_pkg::UC_DATA2 : state;
            ucstats_pkg::UC_DATA2:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        valid_rise ? ucstats_pkg::UC_DATA3 : state;
            // interval done has no ram word behind it
            ucstats_pkg::UC_DATA3:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        !valid_rise ? state :
                        is_interval ? ucstats_pkg::UC_DATA0_B : ucstats_pkg::UC_WR_RAM;
            ucstats_pkg::UC_WR_RAM:
               state <= ucstats_pkg::UC_DATA0_B;
            ucstats_pkg::UC_RD_RAM:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE : ucstats_pkg::UC_RD_MASTER;
            // valid fall first, then master release, avoids racing the uc turnaround
            ucstats_pkg::UC_RD_MASTER:
               state <= valid_fall ? ucstats_pkg::UC_RD_MASTER2 : state;
            ucstats_pkg::UC_RD_MASTER2:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        !master_db ? ucstats_pkg::UC_RD_DRIVE0 : state;
            // one byte per valid fall, low byte first
            ucstats_pkg::UC_RD_DRIVE0:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        valid_fall ? ucstats_pkg::UC_RD_DRIVE1 : state;
            ucstats_pkg::UC_RD_DRIVE1:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        valid_fall ? ucstats_pkg::UC_RD_DRIVE2 : state;
            ucstats_pkg::UC_RD_DRIVE2:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        valid_fall ? ucstats_pkg::UC_RD_DRIVE3 : state;
            ucstats_pkg::UC_RD_DRIVE3:
               state <= !cs_db ? ucstats_pkg::UC_EARLY_DONE :
                        valid_fall ? ucstats_pkg::UC_RD_DONE : state;
            ucstats_pkg::UC_RD_DONE,
            ucstats_pkg::UC_INVALID_WR:
               state <= !cs_db ? ucstats_pkg::UC_DONE : state;
            ucstats_pkg::UC_EARLY_DONE,
            ucstats_pkg::UC_DONE:
               state <= ucstats_pkg::UC_IDLE;
            default:
               state <= ucstats_pkg::UC_ERROR;
         endcase
      end
   end

   // --------------------
   // address and data
   // --------------------
   always_ff @(posedge clk) begin
      if (valid_rise && state == ucstats_pkg::UC_ADDR0) begin
         uc_addr[7:0] <= data_sync;
      end else if (valid_rise && state == ucstats_pkg::UC_ADDR1) begin
         uc_addr[15:8] <= data_sync;
      end else if (state == ucstats_pkg::UC_WR_RAM) begin
         // auto increment for the next word of a burst
         uc_addr <= uc_addr + 16'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (valid_rise) begin
         case (state)
            ucstats_pkg::UC_DATA0,
            ucstats_pkg::UC_DATA0_B: uc_wr_data[7:0]   <= data_sync;
            ucstats_pkg::UC_DATA1:   uc_wr_data[15:8]  <= data_sync;
            ucstats_pkg::UC_DATA2:   uc_wr_data[23:16] <= data_sync;
            ucstats_pkg::UC_DATA3:   uc_wr_data[31:24] <= data_sync;
            default:                 uc_wr_data        <= uc_wr_data;
         endcase
      end
   end

   // decode
   assign is_write     = uc_addr[15];
   assign is_stat      = uc_addr[11:10] == ucstats_pkg::SPACE_STAT;
   assign is_fpga      = uc_addr[11:10] == ucstats_pkg::SPACE_FPGA;
   assign is_interval  = is_write & is_fpga & (uc_addr[9:0] == ucstats_pkg::OFS_INTERVAL_DONE);
   assign is_id_read   = ~is_write & is_fpga & (uc_addr[9:0] == ucstats_pkg::OFS_ID_CODE);
   // reserved bits set, or an fpga offset used in the wrong direction
   assign invalid_addr = (|uc_addr[14:11]) | (is_fpga & ~is_interval & ~is_id_read);

   assign uc_ram_addr    = uc_addr[9:0];
   assign wr_pulse       = state == ucstats_pkg::UC_WR_RAM;
   assign rd_pulse       = state == ucstats_pkg::UC_RD_RAM;
   assign interval_pulse = (state == ucstats_pkg::UC_DATA3) & cs_db & valid_rise & is_interval;

   // --------------------
   // read return
   // --------------------
   // ram word is back one cycle after the read state
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         rd_issued <= 1'b0;
      end else begin
         rd_issued <= rd_pulse;
      end
   end

   always_ff @(posedge clk) begin
      if (state == ucstats_pkg::UC_ADDR_DEC && invalid_addr) begin
         data_to_uc <= ucstats_pkg::BAD_ADDR_WORD;
      end else if (state == ucstats_pkg::UC_ADDR_DEC && is_id_read) begin
         data_to_uc <= ucstats_pkg::ID_CODE;
      end else if (rd_issued) begin
         data_to_uc <= uc_rd_data;
      end
   end

   always_comb begin
      case (state)
         ucstats_pkg::UC_RD_DRIVE0: uc_data_out = data_to_uc[7:0];
         ucstats_pkg::UC_RD_DRIVE1: uc_data_out = data_to_uc[15:8];
         ucstats_pkg::UC_RD_DRIVE2: uc_data_out = data_to_uc[23:16];
         default:                   uc_data_out = data_to_uc[31:24];
      endcase
   end

   assign uc_data_out_val = state inside {ucstats_pkg::UC_RD_DRIVE0, ucstats_pkg::UC_RD_DRIVE1,
                                          ucstats_pkg::UC_RD_DRIVE2, ucstats_pkg::UC_RD_DRIVE3};

   // bus turnaround only after the uc let go of master and while still selected
   assert property (@(posedge clk) disable iff (!uc_rst_n)
      $rose(uc_data_out_val) |-> (!master_db && cs_db));

   assert property (@(posedge clk) disable iff (!uc_rst_n)
      state != ucstats_pkg::UC_ERROR);

endmodule

// ==== hdl/stat_bank_arbiter.sv ====
`timescale 1ns/1ps
// stat bank fsm, write bank select, link engine read window and bank port steering
module stat_bank_arbiter (
   input  logic                    clk,
   input  logic                    uc_rst_n,
   input  logic                    wr_pulse,
   input  logic                    interval_pulse,
   input  logic                    rd_pulse,
   input  ucstats_pkg::ram_addr_t  uc_ram_addr,
   input  ucstats_pkg::ram_addr_t  le_addr,
   input  logic                    le_req,
   input  logic                    le_done,
   input  ucstats_pkg::stat_word_t rd_data0,
   input  ucstats_pkg::stat_word_t rd_data1,
   output logic                    le_gnt,
   output logic                    wr_en0,
   output logic                    wr_en1,
   output ucstats_pkg::ram_addr_t  rd_addr0,
   output ucstats_pkg::ram_addr_t  rd_addr1,
   output ucstats_pkg::stat_word_t uc_rd_data,
   output ucstats_pkg::stat_word_t le_data
);

   ucstats_pkg::bank_state_t bank_state;
   // 0 means the uc owns bank0 and the link engine reads bank1
   logic                     wr_bank;
   logic                     uc_rd_bank;
   logic                     le_reading_q;
   logic                     le_reading;

   // --------------------
   // bank fsm
   // --------------------
   // swap once an interval is closed and no link engine window is open
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         bank_state <= ucstats_pkg::BANK_IDLE;
      end else begin
         case (bank_state)
            ucstats_pkg::BANK_IDLE:
               bank_state <= wr_pulse ? ucstats_pkg::BANK_WRITING : bank_state;
            ucstats_pkg::BANK_WRITING:
               bank_state <= interval_pulse ? ucstats_pkg::BANK_INTERVAL_DONE : bank_state;
            // held off by a read, a fresh write reopens the interval
            ucstats_pkg::BANK_INTERVAL_DONE:
               bank_state <= le_reading ? bank_state :
                             wr_pulse ? ucstats_pkg::BANK_WRITING : ucstats_pkg::BANK_UPDATE;
            ucstats_pkg::BANK_UPDATE:
               bank_state <= ucstats_pkg::BANK_IDLE;
            default:
               bank_state <= ucstats_pkg::BANK_ERROR;
         endcase
      end
   end

   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         wr_bank      <= 1'b0;
         uc_rd_bank   <= 1'b0;
         le_reading_q <= 1'b0;
         le_gnt       <= 1'b0;
      end else begin
         if (bank_state == ucstats_pkg::BANK_UPDATE) begin
            wr_bank <= ~wr_bank;
         end
         // remember which bank the uc read went to, data returns next cycle
         if (rd_pulse) begin
            uc_rd_bank <= wr_bank;
         end
         // window opens on request, closes on done
         if (le_req) begin
            le_reading_q <= 1'b1;
         end else if (le_done) begin
            le_reading_q <= 1'b0;
         end
         le_gnt <= le_req;
      end
   end

   assign le_reading = le_reading_q | le_req;

   // --------------------
   // port steering
   // --------------------
   assign wr_en0   = wr_pulse & ~wr_bank;
   assign wr_en1   = wr_pulse & wr_bank;
   assign rd_addr0 = wr_bank ? le_addr : uc_ram_addr;
   assign rd_addr1 = wr_bank ? uc_ram_addr : le_addr;

   assign uc_rd_data = uc_rd_bank ? rd_data1 : rd_data0;

   // output flop gives the two cycle address to data latency
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         le_data <= '0;
      end else begin
         le_data <= wr_bank ? rd_data0 : rd_data1;
      end
   end

   // one request per read window
   assert property (@(posedge clk) disable iff (!uc_rst_n)
      $rose(le_req) |-> !le_reading_q);

   assert property (@(posedge clk) disable iff (!uc_rst_n)
      le_done |-> le_reading_q);

   assert property (@(posedge clk) disable iff (!uc_rst_n)
      bank_state != ucstats_pkg::BANK_ERROR);

endmodule

// ==== hdl/stat_ram.sv ====
`timescale 1ns/1ps
// one stat bank, 1024 words with synchronous write and registered read
module stat_ram (
   input  logic                    clk,
   input  logic                    wr_en,
   input  ucstats_pkg::ram_addr_t  wr_addr,
   input  ucstats_pkg::ram_addr_t  rd_addr,
   input  ucstats_pkg::stat_word_t wr_data,
   output ucstats_pkg::stat_word_t rd_data
);

   // 32 sfps of 32 words each
   ucstats_pkg::stat_word_t mem [2**$bits(ucstats_pkg::ram_addr_t)];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== hdl/ucstats_top.sv ====
`timescale 1ns/1ps
// stat bridge top, uc sync stage, transfer fsm, bank arbiter and two stat banks
module ucstats_top #(
   parameter int DEBOUNCE_LEN = 2
) (
   input  logic                    clk,
   input  logic                    uc_rst_n,
   // uc pins
   input  logic                    uc_cs,
   input  logic                    uc_valid,
   input  logic                    uc_master,
   input  ucstats_pkg::uc_byte_t   uc_data_in,
   output ucstats_pkg::uc_byte_t   uc_data_out,
   output logic                    uc_data_out_val,
   // link engine port
   input  logic                    le_req,
   input  ucstats_pkg::ram_addr_t  le_addr,
   input  logic                    le_done,
   output logic                    le_gnt,
   output ucstats_pkg::stat_word_t le_data
);

   logic                    cs_db;
   logic                    master_db;
   logic                    valid_rise;
   logic                    valid_fall;
   ucstats_pkg::uc_byte_t   data_sync;
   logic                    wr_pulse;
   logic                    rd_pulse;
   logic                    interval_pulse;
   ucstats_pkg::ram_addr_t  uc_ram_addr;
   ucstats_pkg::stat_word_t uc_wr_data;
   ucstats_pkg::stat_word_t uc_rd_data;
   logic                    wr_en0;
   logic                    wr_en1;
   ucstats_pkg::ram_addr_t  rd_addr0;
   ucstats_pkg::ram_addr_t  rd_addr1;
   ucstats_pkg::stat_word_t rd_data0;
   ucstats_pkg::stat_word_t rd_data1;

   uc_input_sync #(
      .DEBOUNCE_LEN (DEBOUNCE_LEN)
   ) u_sync (
      .clk        (clk),
      .uc_rst_n   (uc_rst_n),
      .uc_cs      (uc_cs),
      .uc_valid   (uc_valid),
      .uc_master  (uc_master),
      .uc_data_in (uc_data_in),
      .cs_db      (cs_db),
      .master_db  (master_db),
      .valid_rise (valid_rise),
      .valid_fall (valid_fall),
      .data_sync  (data_sync)
   );

   uc_xfer_fsm u_fsm (
      .clk             (clk),
      .uc_rst_n        (uc_rst_n),
      .cs_db           (cs_db),
      .master_db       (master_db),
      .valid_rise      (valid_rise),
      .valid_fall      (valid_fall),
      .data_sync       (data_sync),
      .uc_rd_data      (uc_rd_data),
      .wr_pulse        (wr_pulse),
      .rd_pulse        (rd_pulse),
      .interval_pulse  (interval_pulse),
      .uc_ram_addr     (uc_ram_addr),
      .uc_wr_data      (uc_wr_data),
      .uc_data_out     (uc_data_out),
      .uc_data_out_val (uc_data_out_val)
   );

   stat_bank_arbiter u_arb (
      .clk            (clk),
      .uc_rst_n       (uc_rst_n),
      .wr_pulse       (wr_pulse),
      .interval_pulse (interval_pulse),
      .rd_pulse       (rd_pulse),
      .uc_ram_addr    (uc_ram_addr),
      .le_addr        (le_addr),
      .le_req         (le_req),
      .le_done        (le_done),
      .rd_data0       (rd_data0),
      .rd_data1       (rd_data1),
      .le_gnt         (le_gnt),
      .wr_en0         (wr_en0),
      .wr_en1         (wr_en1),
      .rd_addr0       (rd_addr0),
      .rd_addr1       (rd_addr1),
      .uc_rd_data     (uc_rd_data),
      .le_data        (le_data)
   );

   // both banks take the uc write word and address and the arbiter picks which one enables
   stat_ram bank0 (
      .clk     (clk),
      .wr_en   (wr_en0),
      .wr_addr (uc_ram_addr),
      .rd_addr (rd_addr0),
      .wr_data (uc_wr_data),
      .rd_data (rd_data0)
   );

   stat_ram bank1 (
      .clk     (clk),
      .wr_en   (wr_en1),
      .wr_addr (uc_ram_addr),
      .rd_addr (rd_addr1),
      .wr_data (uc_wr_data),
      .rd_data (rd_data1)
   );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
// testbench clock source and power-on reset generator
module tb_clock #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic uc_rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // reset lets go mid cycle, clear of the active edge
   initial begin
      uc_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      uc_rst_n = 1'b1;
   end

endmodule

// ==== test/uc_bus_tasks.svh ====
// uc and link engine bus tasks, lfsr word source, address frame helper and value checks
`ifndef UC_BUS_TASKS_SVH
`define UC_BUS_TASKS_SVH

// --------------------
// checks and stimulus
// --------------------
task automatic expect_value(input string sig_name, input logic [31:0] exp,
                            input logic [31:0] act);
   assert (act === exp) else begin
      $display("error at %0t: %s expected %h got %h", $time, sig_name, exp, act);
      stop_with_failure();
   end
endtask

// galois form, taps 32 31 29 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
endfunction

// one lfsr step for every data bit
function automatic ucstats_pkg::stat_word_t random_word();
   ucstats_pkg::stat_word_t w;
   w = '0;
   for (int i = 0; i < 32; i++) begin
      w          = {w[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
   end
   return w;
endfunction

// stat space frame, write flag on top and offset in the low ten bits
function automatic ucstats_pkg::uc_addr_t stat_addr(input logic wr, input int ofs);
   return {wr, 5'b00000, ofs[9:0]};
endfunction

// all pins move a fixed delay after the rising edge
task automatic next_cycle();
   @(posedge clk);
   #(DRIVE_DLY_NS);
endtask

task automatic hold_cycles(input int n);
   repeat (n) next_cycle();
endtask

// --------------------
// uc side
// --------------------
// data and valid go up together, data beats valid through the debounce
task automatic send_byte(input ucstats_pkg::uc_byte_t b);
   uc_data_in = b;
   uc_valid   = 1'b1;
   hold_cycles(HOLD_CYCLES);
   uc_valid   = 1'b0;
   hold_cycles(HOLD_CYCLES);
endtask

task automatic uc_select(input ucstats_pkg::uc_addr_t addr);
   uc_cs = 1'b1;
   hold_cycles(HOLD_CYCLES);
   send_byte(addr[7:0]);
   send_byte(addr[15:8]);
endtask

task automatic uc_release();
   uc_cs = 1'b0;
   hold_cycles(HOLD_CYCLES);
endtask

// burst of random words, each one mirrored into the uc bank of the model
task automatic uc_write_stat(input int base, input int n);
   ucstats_pkg::stat_word_t w;
   uc_select(stat_addr(1'b1, base));
   for (int i = 0; i < n; i++) begin
      w = random_word();
      for (int b = 0; b < 4; b++) begin
         send_byte(w[8*b +: 8]);
      end
      model_mem[model_wr_bank][base + i] = w;
   end
   uc_release();
endtask

// fewer than four bytes ends the word early with a cs drop
task automatic uc_write_raw(input ucstats_pkg::uc_addr_t addr,
                            input ucstats_pkg::stat_word_t w, input int nbytes);
   uc_select(addr);
   for (int b = 0; b < nbytes; b++) begin
      send_byte(w[8*b +: 8]);
   end
   uc_release();
endtask

task automatic uc_read_check(input ucstats_pkg::uc_addr_t addr,
                             input ucstats_pkg::stat_word_t exp);
   int waited;
   uc_select(addr);
   // hand the data bus over to the bridge
   uc_master = 1'b0;
   waited    = 0;
   while (uc_data_out_val !== 1'b1 && waited < 2 * HOLD_CYCLES) begin
      next_cycle();
      waited++;
   end
   assert (uc_data_out_val === 1'b1) else begin
      $display("read of address %h never drove data back to the uc", addr);
      stop_with_failure();
   end
   // low byte first, a valid fall moves on to the next byte
   for (int b = 0; b < 4; b++) begin
      expect_value("uc_data_out_val", 1, uc_data_out_val);
      expect_value("uc_data_out", exp[8*b +: 8], uc_data_out);
      uc_valid = 1'b1;
      hold_cycles(HOLD_CYCLES);
      uc_valid = 1'b0;
      hold_cycles(HOLD_CYCLES);
   end
   expect_value("uc_data_out_val", 0, uc_data_out_val);
   uc_release();
   uc_master = 1'b1;
   hold_cycles(HOLD_CYCLES);
endtask

// --------------------
// link engine side
// --------------------
// grant one cycle after the request, request drops once grant is seen
task automatic le_open();
   le_req = 1'b1;
   next_cycle();
   expect_value("le_gnt", 1, le_gnt);
   le_req = 1'b0;
   next_cycle();
   expect_value("le_gnt", 0, le_gnt);
endtask

// new address every cycle, two reads in flight, expected from the bank not being written
task automatic le_read_check(input int base, input int n);
   for (int i = 0; i < n + 2; i++) begin
      if (i >= 2) begin
         expect_value("le_data", model_mem[~model_wr_bank][base + i - 2], le_data);
      end
      if (i < n) begin
         le_addr = 10'(base + i);
      end
      next_cycle();
   end
endtask

task automatic le_close();
   le_done = 1'b1;
   next_cycle();
   le_done = 1'b0;
   next_cycle();
endtask

`endif

// ==== test/ucstats_tb.sv ====
`timescale 1ns/1ps
// testbench top with bank model, pin level assertion, stimulus sequence and watchdog
module ucstats_tb;

   localparam int DEBOUNCE_LEN   = 2;
   localparam int DRIVE_DLY_NS   = 10;
   // each pin level stays put well past sync plus debounce
   localparam int HOLD_CYCLES    = 8;
   // about 40 transfers of up to 10 beats at 20 cycles a beat, plus margin
   localparam int TIMEOUT_CYCLES = 12000;
   localparam logic [31:0] LFSR_SEED = 32'h1755_3F7F;

   // sfp 2 word 5 and sfp 31 word 0
   localparam int BASE_A = 10'h045;
   localparam int BASE_B = 10'h3E0;
   localparam ucstats_pkg::uc_addr_t ADDR_INTERVAL_DONE = 16'h8401;
   localparam ucstats_pkg::uc_addr_t ADDR_ID_CODE       = 16'h0402;
   localparam ucstats_pkg::uc_addr_t ADDR_UNUSED        = 16'h0403;

   logic                    clk;
   logic                    uc_rst_n;
   logic                    uc_cs;
   logic                    uc_valid;
   logic                    uc_master;
   ucstats_pkg::uc_byte_t   uc_data_in;
   ucstats_pkg::uc_byte_t   uc_data_out;
   logic                    uc_data_out_val;
   logic                    le_req;
   ucstats_pkg::ram_addr_t  le_addr;
   logic                    le_done;
   logic                    le_gnt;
   ucstats_pkg::stat_word_t le_data;

   // model of both banks and of the bank the uc writes
   ucstats_pkg::stat_word_t model_mem [2][1024];
   logic                    model_wr_bank;
   logic [31:0]             lfsr_state;
   int                      cycle_count;

   tb_clock #(
      .PERIOD_NS    (100),
      .RESET_CYCLES (8)
   ) u_clock (
      .clk      (clk),
      .uc_rst_n (uc_rst_n)
   );

   ucstats_top #(
      .DEBOUNCE_LEN (DEBOUNCE_LEN)
   ) UUT (
      .clk             (clk),
      .uc_rst_n        (uc_rst_n),
      .uc_cs           (uc_cs),
      .uc_valid        (uc_valid),
      .uc_master       (uc_master),
      .uc_data_in      (uc_data_in),
      .uc_data_out     (uc_data_out),
      .uc_data_out_val (uc_data_out_val),
      .le_req          (le_req),
      .le_addr         (le_addr),
      .le_done         (le_done),
      .le_gnt          (le_gnt),
      .le_data         (le_data)
   );

   task automatic stop_with_failure();
      $display("Result: FAILED");
      $fatal(1);
   endtask

   `include "uc_bus_tasks.svh"

   // bridge drives the bus only once the uc has let go of master and is still selected
   assert property (@(posedge clk) disable iff (!uc_rst_n)
      (uc_master || !uc_cs) |-> !uc_data_out_val)
   else begin
      $display("error at %0t: uc_data_out_val expected 0 got 1", $time);
      stop_with_failure();
   end

   initial begin : watchdog
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the test sequence never finished", cycle_count);
      stop_with_failure();
   end

   initial begin : stimulus
      uc_cs         = 1'b0;
      uc_valid      = 1'b0;
      uc_master     = 1'b1;
      uc_data_in    = '0;
      le_req        = 1'b0;
      le_addr       = '0;
      le_done       = 1'b0;
      model_wr_bank = 1'b0;
      lfsr_state    = LFSR_SEED;
      @(posedge uc_rst_n);

      // --------------------
      // reset and uc side
      // --------------------
      // reset values, sampled mid cycle as reset lets go
      expect_value("uc_data_out_val", 0, uc_data_out_val);
      expect_value("le_gnt", 0, le_gnt);
      expect_value("le_data", 0, le_data);
      next_cycle();

      // bursts with auto increment, then read back one word at a time
      uc_write_stat(BASE_A, 4);
      uc_write_stat(BASE_B, 2);
      for (int i = 0; i < 4; i++) begin
         uc_read_check(stat_addr(1'b0, BASE_A + i), model_mem[model_wr_bank][BASE_A + i]);
      end
      uc_read_check(stat_addr(1'b0, BASE_B + 1), model_mem[model_wr_bank][BASE_B + 1]);

      // id code, reserved bit 12 set, unused fpga offset
      uc_read_check(ADDR_ID_CODE, ucstats_pkg::ID_CODE);
      uc_read_check(16'h1000 | stat_addr(1'b0, BASE_A), ucstats_pkg::BAD_ADDR_WORD);
      uc_read_check(ADDR_UNUSED, ucstats_pkg::BAD_ADDR_WORD);

      // reserved bit 13 on a write, then a word cut short after two bytes
      uc_write_raw(16'h2000 | stat_addr(1'b1, BASE_A), 32'h5A5A_A5A5, 4);
      uc_read_check(stat_addr(1'b0, BASE_A), model_mem[model_wr_bank][BASE_A]);
      uc_write_raw(stat_addr(1'b1, BASE_A + 1), 32'h0BAD_F00D, 2);
      uc_read_check(stat_addr(1'b0, BASE_A + 1), model_mem[model_wr_bank][BASE_A + 1]);

      // --------------------
      // bank swap
      // --------------------
      // link engine idle, so the swap is done before cs has settled low
      uc_write_raw(ADDR_INTERVAL_DONE, 32'h0000_0001, 4);
      model_wr_bank = ~model_wr_bank;
      le_open();
      le_read_check(BASE_A, 4);
      le_read_check(BASE_B, 2);
      le_close();

      // second interval goes to the other bank and uc reads follow it
      uc_write_stat(BASE_A, 4);
      uc_read_check(stat_addr(1'b0, BASE_A), model_mem[model_wr_bank][BASE_A]);
      uc_read_check(stat_addr(1'b0, BASE_A + 3), model_mem[model_wr_bank][BASE_A + 3]);

      // read window held open across interval done keeps the old bank visible until le_done
      le_open();
      le_read_check(BASE_A, 4);
      uc_write_raw(ADDR_INTERVAL_DONE, 32'h0000_0002, 4);
      le_read_check(BASE_A, 4);
      le_close();
      hold_cycles(4);
      model_wr_bank = ~model_wr_bank;

      // fresh window sees the second interval
      le_open();
      le_read_check(BASE_A, 4);
      le_close();
      // uc side is back on the first interval's bank
      uc_read_check(stat_addr(1'b0, BASE_A + 2), model_mem[model_wr_bank][BASE_A + 2]);

      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+test
hdl/ucstats_pkg.sv
hdl/uc_input_sync.sv
hdl/uc_xfer_fsm.sv
hdl/stat_bank_arbiter.sv
hdl/stat_ram.sv
hdl/ucstats_top.sv
test/tb_clock.sv
test/ucstats_tb.sv

// ==== Bender.yml ====
package:
  name: ucstats

sources:
  - files:
      - hdl/ucstats_pkg.sv
      - hdl/uc_input_sync.sv
      - hdl/uc_xfer_fsm.sv
      - hdl/stat_bank_arbiter.sv
      - hdl/stat_ram.sv
      - hdl/ucstats_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_clock.sv
      - test/ucstats_tb.sv
